// File: build.f
+incdir+design
design/plca_pkg.sv
design/plca_rx_decode.sv
design/plca_control.sv
design/plca_tx_path.sv
design/plca_rs.sv
dv/tb_clock.sv
dv/plca_rs_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= plca_rs_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/plca_rs_tb.sv
`include "plca_cfg.svh"

module plca_rs_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import plca_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam int NIB_MAX   = `PLCA_FRAME_DEPTH + 8;     // room for an overlong frame
    localparam int NODES     = 4;
    localparam int PERIOD    = `PLCA_BEACON_CYCLES + NODES * `PLCA_TO_CYCLES;

    typedef struct packed {
        plca_cfg_t cfg;
        int        beacon_at;     // driven rx beacon, -1 none
        int        crs_at;
        int        crs_len;       // 0 no carrier
        int        frame_at;
        int        frame_len;
        int        exp_start;     // first tx_en cycle, -1 never
        int        run_len;
    } test_t;

    logic       TX_CLK;
    logic       reset;
    logic       rst_req;
    mii_rx_t    mii_rx;
    logic       crs;
    mac_tx_t    mac_tx;
    plca_cfg_t  cfg;
    mii_tx_t    mii_tx;

    test_t      tests [NUM_TESTS];
    string      test_name [NUM_TESTS];
    logic [3:0] nibs [NUM_TESTS][NIB_MAX];
    int         cycles = 0;
    int         limit = 1000000;       // replaced once the table is built

    tb_clock clk_gen (
        .rst_req (rst_req),
        .TX_CLK  (TX_CLK),
        .reset   (reset)
    );

    plca_rs UUT (
        .TX_CLK  (TX_CLK),
        .reset   (reset),
        .mii_rx  (mii_rx),
        .crs     (crs),
        .mac_tx  (mac_tx),
        .cfg     (cfg),
        .mii_tx  (mii_tx)
    );

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("ERROR %s expected 0x%0h actual 0x%0h", name, exp, act);
            $display("Errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic plca_cfg_t make_cfg(input logic en, input int id);
        plca_cfg_t c;
        c.plca_en       = en;
        c.local_node_id = 8'(id);
        c.node_count    = 8'(NODES);
        return c;
    endfunction

    function automatic test_t blank_entry();
        test_t e;
        e           = '0;
        e.beacon_at = -1;
        e.crs_at    = -1;
        e.exp_start = -1;
        return e;
    endfunction

    // start of tx_en for a node waiting on a received beacon
    function automatic int turn_start(input int beacon_at, input int id, input int crs_at,
                                      input int crs_len);
        int opp;
        int seen;
        int j;
        opp  = beacon_at + `PLCA_BEACON_CYCLES + 1;   // opportunity 0, decoded beacon gone
        seen = crs_at + 1;                            // carrier after the rx register
        for (j = 0; j < id; j++)
        begin
            if (crs_len > 0 && seen >= opp && seen < opp + `PLCA_TO_CYCLES)
            begin
                opp = seen + crs_len + 1;     // frozen, advances the cycle after
            end
            else
            begin
                opp = opp + `PLCA_TO_CYCLES;
            end
        end
        return opp + 1;   // strobe to first nibble
    endfunction

    // expected {tx_en, tx_er, txd} in cycle t after reset
    function automatic logic [5:0] expect_mii(input int idx, input int t);
        test_t tc;
        int    start;
        int    sent;
        tc    = tests[idx];
        start = tc.exp_start;
        sent  = (tc.frame_len > `PLCA_FRAME_DEPTH) ? `PLCA_FRAME_DEPTH : tc.frame_len;
        if (start >= 0 && t >= start && t < start + sent)
        begin
            return {1'b1, 1'b0, nibs[idx][t - start]};
        end
        if (tc.cfg.plca_en && tc.cfg.local_node_id == '0 && t >= 1 &&
            (t - 1) % PERIOD < `PLCA_BEACON_CYCLES)
        begin
            return {2'b01, `PLCA_BEACON_TXD};     // node 0 beacon
        end
        return '0;
    endfunction

    task automatic drive_inputs(input int idx, input int t);
        test_t tc;
        int    b;
        int    c;
        tc     = tests[idx];
        b      = tc.beacon_at;
        c      = tc.crs_at;
        mii_rx = '0;
        crs    = 1'b0;
        mac_tx = '0;
        if (b >= 0 && t >= b && t < b + `PLCA_BEACON_CYCLES)
        begin
            mii_rx.rx_er = 1'b1;
            mii_rx.rxd   = `PLCA_BEACON_TXD;
            crs          = 1'b1;                  // PHY carrier during the beacon
        end
        else if (tc.crs_len > 0 && t >= c && t < c + tc.crs_len)
        begin
            mii_rx.rx_dv = 1'b1;
            mii_rx.rxd   = 4'h5;                  // preamble from another node
            crs          = 1'b1;
        end
        if (t >= tc.frame_at && t < tc.frame_at + tc.frame_len)
        begin
            mac_tx.en     = 1'b1;
            mac_tx.nibble = nibs[idx][t - tc.frame_at];
        end
    endtask

    task automatic build_table();
        int i;
        int k;
        int total;
        for (i = 0; i < NUM_TESTS; i++)
        begin
            tests[i] = blank_entry();
            for (k = 0; k < NIB_MAX; k++)
            begin
                nibs[i][k] = 4'($urandom);
            end
        end
        test_name[0]     = "beacon_node0";          // idle head, three beacons
        tests[0].cfg     = make_cfg(1'b1, 0);
        tests[0].run_len = 2 * PERIOD + 9;
        for (i = 1; i <= 2; i++)
        begin
            tests[i].cfg       = make_cfg(1'b1, 2);
            tests[i].frame_at  = 2;
            tests[i].frame_len = 1 + int'($urandom % `PLCA_FRAME_DEPTH);
            tests[i].beacon_at = tests[i].frame_len + 5;   // frame complete before it
        end
        test_name[1]       = "turn_node2";
        tests[1].exp_start = turn_start(tests[1].beacon_at, 2, -1, 0);
        test_name[2]       = "carrier_node2";
        // carrier seen from the last cycle of opportunity 1
        tests[2].crs_at    = tests[2].beacon_at + `PLCA_BEACON_CYCLES + 2 * `PLCA_TO_CYCLES - 1;
        tests[2].crs_len   = 3 + int'($urandom % 12);
        tests[2].exp_start = turn_start(tests[2].beacon_at, 2, tests[2].crs_at,
                                        tests[2].crs_len);
        test_name[3]       = "no_plca";
        tests[3].frame_len = 1 + int'($urandom % `PLCA_FRAME_DEPTH);
        test_name[4]       = "overflow";
        tests[4].frame_len = `PLCA_FRAME_DEPTH + 1 + int'($urandom % 8);
        for (i = 3; i <= 4; i++)
        begin
            tests[i].cfg       = make_cfg(1'b0, 1);
            tests[i].frame_at  = 3;
            tests[i].exp_start = tests[i].frame_at + tests[i].frame_len + 2;  // en fall + 2
        end
        test_name[5]       = "no_beacon_node1";     // frame held forever
        tests[5].cfg       = make_cfg(1'b1, 1);
        tests[5].frame_at  = 2;
        tests[5].frame_len = 1 + int'($urandom % `PLCA_FRAME_DEPTH);
        tests[5].run_len   = tests[5].frame_len + 2 * PERIOD;
        total = 0;
        for (i = 0; i < NUM_TESTS; i++)
        begin
            if (i >= 1 && i <= 4)
            begin
                tests[i].run_len = tests[i].exp_start + tests[i].frame_len + 8;
            end
            total = total + tests[i].run_len;
        end
        limit = 2 * total + 100;
    endtask

    task automatic run_test(input int idx);
        int         t;
        int         first_tx;
        logic [5:0] want;
        first_tx = -1;
        @(negedge TX_CLK);
        rst_req = 1'b1;
        @(negedge TX_CLK);
        rst_req = 1'b0;                 // reset now high for 8 cycles
        cfg     = tests[idx].cfg;
        mii_rx  = '0;
        crs     = 1'b0;
        mac_tx  = '0;
        while (reset)
        begin
            @(negedge TX_CLK);
        end
        for (t = 0; t < tests[idx].run_len; t++)
        begin
            want = expect_mii(idx, t);
            check($sformatf("%s cycle %0d", test_name[idx], t), 32'(want), 32'(mii_tx));
            if (mii_tx.tx_en && first_tx < 0)
            begin
                first_tx = t;
            end
            drive_inputs(idx, t);
            @(negedge TX_CLK);
        end
        check({test_name[idx], " start"}, tests[idx].exp_start, first_tx);
    endtask

    always @(posedge TX_CLK)
    begin
        cycles = cycles + 1;
        if (cycles > limit)
        begin
            $display("Errors found");
            $fatal(1, "run timed out after %0d cycles", cycles);
        end
    end

    initial
    begin
        int i;
        void'($urandom(32'h6f5a));
        rst_req = 1'b0;
        mii_rx  = '0;
        crs     = 1'b0;
        mac_tx  = '0;
        cfg     = '0;
        build_table();
        for (i = 0; i < NUM_TESTS; i++)
        begin
            run_test(i);
        end
        $display("No errors");
        $finish;
    end

endmodule

// File: dv/tb_clock.sv
module tb_clock (
    input  logic rst_req,       // restart the reset sequence
    output logic TX_CLK,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [3:0] rst_cnt = 4'd8;   // reset cycles still to go

    initial
    begin
        TX_CLK = 1'b0;
        forever #4 TX_CLK = ~TX_CLK;    // 8 ns period
    end

    always @(posedge TX_CLK)
    begin
        if (rst_req)
        begin
            rst_cnt <= 4'd8;
        end
        else if (rst_cnt != 4'd0)
        begin
            rst_cnt <= rst_cnt - 4'd1;
        end
    end

    assign reset = (rst_cnt != 4'd0);

endmodule

// File: design/plca_rs.sv
module plca_rs (
    input  logic                TX_CLK,
    input  logic                reset,
    input  plca_pkg::mii_rx_t   mii_rx,
    input  logic                crs,
    input  plca_pkg::mac_tx_t   mac_tx,
    input  plca_pkg::plca_cfg_t cfg,      // stable once out of reset
    output plca_pkg::mii_tx_t   mii_tx
);
    import plca_pkg::*;

    rx_event_t rx_ev;      // decoded receive side
    txop_t     txop;       // beacon level and turn strobe
    logic      tx_busy;    // own frame on the wire

    plca_rx_decode u_rx_decode (
        .TX_CLK  (TX_CLK),
        .reset   (reset),
        .mii_rx  (mii_rx),
        .crs     (crs),
        .rx_ev   (rx_ev)
    );

    // beacon and opportunity cycle
    plca_control u_control (
        .TX_CLK  (TX_CLK),
        .reset   (reset),
        .cfg     (cfg),
        .rx_ev   (rx_ev),
        .tx_busy (tx_busy),
        .txop    (txop)
    );

    // frame buffer and MII encoder
    plca_tx_path u_tx_path (
        .TX_CLK  (TX_CLK),
        .reset   (reset),
        .mac_tx  (mac_tx),
        .txop    (txop),
        .tx_busy (tx_busy),
        .mii_tx  (mii_tx)
    );

endmodule

// File: design/plca_tx_path.sv
`include "plca_cfg.svh"

module plca_tx_path (
    input  logic               TX_CLK,
    input  logic               reset,
    input  plca_pkg::mac_tx_t  mac_tx,
    input  plca_pkg::txop_t    txop,
    output logic               tx_busy,
    output plca_pkg::mii_tx_t  mii_tx
);

    localparam logic [`PLCA_LEN_W-1:0] FULL_LEN = `PLCA_LEN_W'(`PLCA_FRAME_DEPTH);

    logic [`PLCA_NIBBLE_W-1:0] mem [`PLCA_FRAME_DEPTH];   // one frame
    logic [`PLCA_LEN_W-1:0]    len;        // nibbles written
    logic [`PLCA_LEN_W-1:0]    rd_ptr;     // next nibble to send
    logic                      en_q;       // mac en, previous cycle
    logic                      full_q;     // complete frame waiting
    logic                      tx_en_q;
    logic [`PLCA_NIBBLE_W-1:0] txd_q;
    logic                      wr_ok;
    logic                      frame_done;
    logic                      start;
    logic                      last;

    // tail of an overlong frame is dropped
    assign wr_ok      = mac_tx.en && !full_q && !tx_en_q && (len != FULL_LEN);
    assign frame_done = en_q && !mac_tx.en && !full_q && !tx_en_q && (len != '0);
    assign start      = txop.my_turn && full_q && !tx_en_q;
    assign last       = tx_en_q && (rd_ptr == len);   // previous nibble was the last

    always_ff @(posedge TX_CLK)
    begin
        if (reset)
        begin
            len     <= '0;
            rd_ptr  <= '0;
            en_q    <= 1'b0;
            full_q  <= 1'b0;
            tx_en_q <= 1'b0;
        end
        else
        begin
            en_q <= mac_tx.en;
            if (wr_ok)
            begin
                len <= len + `PLCA_LEN_W'(1);
            end
            if (frame_done)
            begin
                full_q <= 1'b1;             // en fell, frame ready to go
            end
            if (start)
            begin
                tx_en_q <= 1'b1;
                rd_ptr  <= `PLCA_LEN_W'(1);  // nibble 0 leaves now
            end
            else if (last)
            begin
                tx_en_q <= 1'b0;
                full_q  <= 1'b0;            // buffer free for the next frame
                len     <= '0;
            end
            else if (tx_en_q)
            begin
                rd_ptr <= rd_ptr + `PLCA_LEN_W'(1);
            end
        end
    end

    // buffer and outgoing nibble
    always_ff @(posedge TX_CLK)
    begin
        if (wr_ok)
        begin
            mem[len[`PLCA_ADDR_W-1:0]] <= mac_tx.nibble;
        end
        if (start)
        begin
            txd_q <= mem[0];
        end
        else if (tx_en_q && !last)
        begin
            txd_q <= mem[rd_ptr[`PLCA_ADDR_W-1:0]];
        end
    end

    assign tx_busy      = tx_en_q;
    assign mii_tx.tx_en = tx_en_q;
    assign mii_tx.tx_er = txop.tx_beacon;            // beacon is sent as an error code
    assign mii_tx.txd   = txop.tx_beacon ? `PLCA_BEACON_TXD :
                          (tx_en_q ? txd_q : '0);    // idle txd at zero

    // control must not start a beacon over our own frame
    a_beacon_idle: assert property (@(posedge TX_CLK) disable iff (reset)
        txop.tx_beacon |-> !tx_busy);

endmodule

// File: design/plca_control.sv
`include "plca_cfg.svh"

module plca_control (
    input  logic                TX_CLK,
    input  logic                reset,
    input  plca_pkg::plca_cfg_t cfg,
    input  plca_pkg::rx_event_t rx_ev,
    input  logic                tx_busy,
    output plca_pkg::txop_t     txop
);
    import plca_pkg::*;

    typedef enum logic [2:0] {
        DISABLED,
        WAIT_BEACON,
        SEND_BEACON,
        OPPORTUNITY,
        HOLD
    } state_e;

    localparam logic [`PLCA_TIMER_W-1:0] TO_LAST =
        `PLCA_TIMER_W'(`PLCA_TO_CYCLES - 1);
    localparam logic [`PLCA_TIMER_W-1:0] BEACON_LAST =
        `PLCA_TIMER_W'(`PLCA_BEACON_CYCLES - 1);

    state_e                   state;
    logic [`PLCA_ID_W-1:0]    cur_id;      // curID of the running opportunity
    logic [`PLCA_TIMER_W-1:0] timer;       // shared by beacon and to timer
    logic [`PLCA_ID_W-1:0]    last_id;
    logic                     is_head;     // node 0 originates the beacons
    logic                     busy;        // medium in use so the count freezes
    logic                     rx_beacon;
    logic                     txop_end;

    assign last_id   = cfg.node_count - `PLCA_ID_W'(1);
    assign is_head   = (cfg.local_node_id == '0);
    assign busy      = rx_ev.receiving || tx_busy;
    assign rx_beacon = !is_head && (rx_ev.cmd == BEACON);   // node 0 ignores its echo

    // opportunity ends when the idle timer runs out or the medium goes quiet
    assign txop_end = !busy &&
                      ((state == OPPORTUNITY && timer == TO_LAST) || state == HOLD);

    always_ff @(posedge TX_CLK)
    begin
        if (reset)
        begin
            state  <= WAIT_BEACON;
            cur_id <= '0;
            timer  <= '0;
        end
        else if (!cfg.plca_en)
        begin
            state  <= DISABLED;
            cur_id <= '0;
            timer  <= '0;
        end
        else if (rx_beacon)
        begin
            // held at ID 0 until the beacon ends
            state  <= OPPORTUNITY;
            cur_id <= '0;
            timer  <= '0;
        end
        else
        begin
            case (state)
                DISABLED:
                begin
                    state <= WAIT_BEACON;       // plca_en just came up
                end
                WAIT_BEACON:
                begin
                    if (is_head)
                    begin
                        state <= SEND_BEACON;
                        timer <= '0;
                    end
                end
                SEND_BEACON:
                begin
                    if (timer == BEACON_LAST)
                    begin
                        state  <= OPPORTUNITY;
                        cur_id <= '0;
                        timer  <= '0;
                    end
                    else
                    begin
                        timer <= timer + `PLCA_TIMER_W'(1);
                    end
                end
                OPPORTUNITY, HOLD:
                begin
                    if (txop_end)
                    begin
                        timer <= '0;
                        if (cur_id != last_id)
                        begin
                            state  <= OPPORTUNITY;
                            cur_id <= cur_id + `PLCA_ID_W'(1);
                        end
                        else if (is_head)
                        begin
                            state <= SEND_BEACON;   // cycle closed so next beacon
                        end
                        else
                        begin
                            state <= WAIT_BEACON;   // others resync on the beacon
                        end
                    end
                    else if (busy)
                    begin
                        state <= HOLD;              // timer keeps its value
                    end
                    else
                    begin
                        timer <= timer + `PLCA_TIMER_W'(1);
                    end
                end
                default:
                begin
                    state <= WAIT_BEACON;
                end
            endcase
        end
    end

    assign txop.tx_beacon = (state == SEND_BEACON);
    // without PLCA every cycle is a turn
    // a carrier on our first cycle costs the turn
    assign txop.my_turn = (state == DISABLED) ||
                          (state == OPPORTUNITY && timer == '0 &&
                           cur_id == cfg.local_node_id && !rx_ev.receiving);

    a_cur_id_bound: assert property (@(posedge TX_CLK) disable iff (reset)
        cfg.plca_en |-> (cur_id < cfg.node_count));

    // the frame a strobe starts never runs into a beacon
    a_turn_not_beacon: assert property (@(posedge TX_CLK) disable iff (reset)
        txop.my_turn |=> !txop.tx_beacon);

endmodule

// File: design/plca_rx_decode.sv
`include "plca_cfg.svh"

module plca_rx_decode (
    input  logic                TX_CLK,
    input  logic                reset,
    input  plca_pkg::mii_rx_t   mii_rx,
    input  logic                crs,
    output plca_pkg::rx_event_t rx_ev
);
    import plca_pkg::*;

    mii_rx_t rx_q;               // pins one cycle late
    logic    crs_q;
    rx_cmd_e cmd;
    logic    oob;                // out-of-band code on rxd

    // rx clock is the same clock as TX_CLK
    always_ff @(posedge TX_CLK)
    begin
        if (reset)
        begin
            rx_q  <= '0;
            crs_q <= 1'b0;
        end
        else
        begin
            rx_q  <= mii_rx;
            crs_q <= crs;
        end
    end

    assign oob = !rx_q.rx_dv && rx_q.rx_er;

    always_comb
    begin
        cmd = NONE;
        if (oob && rx_q.rxd == `PLCA_BEACON_TXD)
        begin
            cmd = BEACON;
        end
        else if (oob && rx_q.rxd == `PLCA_COMMIT_TXD)
        begin
            cmd = COMMIT;
        end
    end

    assign rx_ev.cmd = cmd;
    // a beacon raises crs but is not traffic
    assign rx_ev.receiving = rx_q.rx_dv || (cmd == COMMIT) || (crs_q && cmd != BEACON);

    // no data on the pins while a beacon is still being decoded
    a_dv_not_beacon: assert property (@(posedge TX_CLK) disable iff (reset)
        (rx_ev.cmd == BEACON) |-> !mii_rx.rx_dv);

endmodule

// File: design/plca_pkg.sv
`include "plca_cfg.svh"

package plca_pkg;

    // receive MII straight from the PHY pins
    typedef struct packed {
        logic                      rx_dv;
        logic                      rx_er;
        logic [`PLCA_NIBBLE_W-1:0] rxd;
    } mii_rx_t;

    // transmit MII towards the PHY
    typedef struct packed {
        logic                      tx_en;
        logic                      tx_er;
        logic [`PLCA_NIBBLE_W-1:0] txd;
    } mii_tx_t;

    // MAC side with en high for the whole frame
    typedef struct packed {
        logic                      en;
        logic [`PLCA_NIBBLE_W-1:0] nibble;
    } mac_tx_t;

    typedef struct packed {
        logic                  plca_en;
        logic [`PLCA_ID_W-1:0] local_node_id;
        logic [`PLCA_ID_W-1:0] node_count;     // bounds the opportunity cycle
    } plca_cfg_t;

    typedef enum logic [1:0] {
        NONE   = 2'd0,
        BEACON = 2'd1,
        COMMIT = 2'd2
    } rx_cmd_e;

    typedef struct packed {
        rx_cmd_e cmd;
        logic    receiving;      // somebody else owns the medium
    } rx_event_t;

    // control -> transmit path
    typedef struct packed {
        logic tx_beacon;         // level for one whole beacon
        logic my_turn;           // strobe at the start of our opportunity
    } txop_t;

endpackage

// File: design/plca_cfg.svh
`ifndef PLCA_CFG_SVH
`define PLCA_CFG_SVH

// mii and node id widths
`define PLCA_NIBBLE_W      4
`define PLCA_ID_W          8      // node id and node count

// PLCA timers in TX_CLK cycles
`define PLCA_TO_CYCLES     8      // one empty transmit opportunity
`define PLCA_BEACON_CYCLES 4
`define PLCA_TIMER_W       4      // wide enough for either count

// store-and-forward frame buffer
`define PLCA_FRAME_DEPTH   64     // nibbles
`define PLCA_ADDR_W        6
`define PLCA_LEN_W         7      // counts 0 up to the full depth

// codes on rxd/txd with dv/en low and er high
`define PLCA_BEACON_TXD    4'b0010
`define PLCA_COMMIT_TXD    4'b0011

`endif
